/* src/video_pkg.sv */
package video_pkg;

    localparam int colidx_w = 4;
    localparam int tram_aw  = 12;   // Word address
    localparam int chram_aw = 11;

    // IO register map, unlisted addresses read zero
    typedef enum logic [3:0] {
        reg_vctrl    = 4'd0,
        reg_vpalsel  = 4'd1,
        reg_vpaldata = 4'd2,
        reg_vline    = 4'd3,
        reg_virqline = 4'd4,
        reg_irqmask  = 4'd5,
        reg_irqstat  = 4'd6
    } reg_addr_e;

    typedef struct packed {
        logic [10:0] hpos;
        logic [9:0]  vpos;
        logic        active;
        logic        hsync;     // Active low
        logic        vsync;     // Active low
        logic        vblank;    // Every non-active line
    } video_timing_s;

    // Syncs inactive, nothing displayed
    localparam video_timing_s timing_idle = '{
        hpos: '0, vpos: '0, active: 1'b0, hsync: 1'b1, vsync: 1'b1, vblank: 1'b0
    };

    typedef struct packed {
        logic invert;           // vctrl[1]
        logic text_enable;      // vctrl[0]
    } video_ctrl_s;

    typedef struct packed {
        logic [3:0] idx;
        logic       high;       // Red nibble, else green/blue byte
        logic [7:0] data;
        logic       wren;
    } pal_wr_s;

endpackage

/* src/video_timing.sv */
module video_timing #(
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int h_sync   = 96,
    parameter int h_back   = 48,
    parameter int v_active = 480,
    parameter int v_front  = 10,
    parameter int v_sync   = 2,
    parameter int v_back   = 33
) (
    input  logic                     vclk,
    input  logic                     reset,
    output video_pkg::video_timing_s timing
);
    import video_pkg::*;

    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;

    typedef enum logic [1:0] {h_active_ph, h_front_ph, h_sync_ph, h_back_ph} h_phase_e;

    h_phase_e    h_ph;
    logic [10:0] h_cnt;
    logic [9:0]  v_cnt;
    logic        h_last;
    logic        v_in_sync;

    assign h_last    = (h_cnt == 11'(h_total - 1));
    assign v_in_sync = (v_cnt >= 10'(v_active + v_front)) &&
                       (v_cnt < 10'(v_active + v_front + v_sync));

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
            h_ph  <= h_active_ph;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                v_cnt <= (v_cnt == 10'(v_total - 1)) ? '0 : v_cnt + 10'd1;
            end else begin
                h_cnt <= h_cnt + 11'd1;
            end
            // Phase follows the counter, one boundary at a time
            case (h_ph)
                h_active_ph: if (h_cnt == 11'(h_active - 1)) h_ph <= h_front_ph;
                h_front_ph:  if (h_cnt == 11'(h_active + h_front - 1)) h_ph <= h_sync_ph;
                h_sync_ph:   if (h_cnt == 11'(h_active + h_front + h_sync - 1)) h_ph <= h_back_ph;
                h_back_ph:   if (h_last) h_ph <= h_active_ph;
                default:     h_ph <= h_active_ph;
            endcase
        end
    end

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            timing <= timing_idle;
        end else begin
            timing.hpos   <= h_cnt;
            timing.vpos   <= v_cnt;
            timing.active <= (h_ph == h_active_ph) && (v_cnt < 10'(v_active));
            timing.hsync  <= (h_ph != h_sync_ph);
            timing.vsync  <= !v_in_sync;
            timing.vblank <= (v_cnt >= 10'(v_active));
        end
    end

    assert property (@(posedge vclk) disable iff (reset) timing.hpos < 11'(h_total))
        else $error("hpos beyond horizontal total");

endmodule

/* src/video_regs.sv */
module video_regs (
    input  logic                     vclk,
    input  logic                     reset,
    input  video_pkg::video_timing_s timing,
    input  logic [3:0]               io_addr,
    input  logic [7:0]               io_wrdata,
    input  logic                     io_wren,
    output logic [7:0]               io_rddata,
    output logic                     irq,
    output video_pkg::video_ctrl_s   ctrl,
    output video_pkg::pal_wr_s       pal_wr,
    input  logic [7:0]               pal_rddata
);
    import video_pkg::*;

    reg_addr_e  addr;
    logic [1:0] vctrl;      // [1] invert, [0] text enable
    logic [4:0] vpalsel;    // [4:1] index, [0] high byte
    logic [7:0] virqline;
    logic [1:0] irqmask;    // [1] line, [0] vblank
    logic [1:0] irqstat;
    logic       vblank_q;
    logic       line_set;
    logic       vblank_set;
    logic [1:0] stat_clr;

    assign addr = reg_addr_e'(io_addr);

    //////////////////////////////////////////////////
    // Interrupt events

    // First pixel of the first line of a doubled pair
    assign line_set   = timing.active && (timing.hpos == '0) && !timing.vpos[0] &&
                        (timing.vpos[9:1] == {1'b0, virqline});
    assign vblank_set = timing.vblank && !vblank_q;
    assign stat_clr   = (io_wren && addr == reg_irqstat) ? io_wrdata[1:0] : 2'b00;

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            vctrl    <= '0;
            vpalsel  <= '0;
            virqline <= '0;
            irqmask  <= '0;
            irqstat  <= '0;
            vblank_q <= 1'b0;
        end else begin
            vblank_q <= timing.vblank;
            if (io_wren) begin
                case (addr)
                    reg_vctrl:    vctrl    <= io_wrdata[1:0];
                    reg_vpalsel:  vpalsel  <= io_wrdata[4:0];
                    reg_virqline: virqline <= io_wrdata;
                    reg_irqmask:  irqmask  <= io_wrdata[1:0];
                    default: ;
                endcase
            end
            irqstat <= (irqstat & ~stat_clr) | {line_set, vblank_set};   // Set wins
        end
    end

    //////////////////////////////////////////////////
    // Read mux and outputs

    always_comb begin
        io_rddata = 8'h00;
        case (addr)
            reg_vctrl:    io_rddata = {6'b0, vctrl};
            reg_vpalsel:  io_rddata = {3'b0, vpalsel};
            reg_vpaldata: io_rddata = pal_rddata;
            reg_vline:    io_rddata = timing.vpos[8:1];     // Text line pairs
            reg_virqline: io_rddata = virqline;
            reg_irqmask:  io_rddata = {6'b0, irqmask};
            reg_irqstat:  io_rddata = {6'b0, irqstat};
            default:      io_rddata = 8'h00;
        endcase
    end

    assign irq    = |(irqstat & irqmask);
    assign ctrl   = video_ctrl_s'(vctrl);
    assign pal_wr = '{idx: vpalsel[4:1], high: vpalsel[0], data: io_wrdata,
                      wren: io_wren && (addr == reg_vpaldata)};

    // Only the CPU can take a pending interrupt away
    assert property (@(posedge vclk) disable iff (reset)
        $fell(irq) |-> $past(io_wren && (addr == reg_irqstat || addr == reg_irqmask)))
        else $error("irq dropped without an irqstat or irqmask write");

endmodule

/* src/text_ram.sv */
module text_ram (
    input  logic                          vclk,
    input  logic [video_pkg::tram_aw:0]   cpu_addr,
    input  logic [7:0]                    cpu_wrdata,
    input  logic                          cpu_wren,
    output logic [7:0]                    cpu_rddata,
    input  logic [video_pkg::tram_aw-1:0] vid_addr,
    output logic [15:0]                   vid_rddata
);
    import video_pkg::*;

    logic [1:0][7:0]    mem [2**tram_aw];   // Lane 1 colour, lane 0 character
    logic [tram_aw-1:0] cpu_word;
    logic               cpu_lane;

    assign cpu_word = cpu_addr[tram_aw:1];
    assign cpu_lane = cpu_addr[0];

    // CPU byte port
    always_ff @(posedge vclk) begin
        if (cpu_wren) begin
            mem[cpu_word][cpu_lane] <= cpu_wrdata;
        end
        cpu_rddata <= mem[cpu_word][cpu_lane];
    end

    always_ff @(posedge vclk) begin
        vid_rddata <= mem[vid_addr];    // Whole word for the pipeline
    end

endmodule

/* src/char_ram.sv */
module char_ram (
    input  logic                           vclk,
    input  logic [video_pkg::chram_aw-1:0] cpu_addr,
    input  logic [7:0]                     cpu_wrdata,
    input  logic                           cpu_wren,
    output logic [7:0]                     cpu_rddata,
    input  logic [video_pkg::chram_aw-1:0] vid_addr,
    output logic [7:0]                     vid_rddata
);
    import video_pkg::*;

    // 256 glyphs of 8 rows, MSB is the leftmost pixel
    logic [7:0] mem [2**chram_aw];

    always_ff @(posedge vclk) begin
        if (cpu_wren) begin
            mem[cpu_addr] <= cpu_wrdata;
        end
        cpu_rddata <= mem[cpu_addr];
    end

    always_ff @(posedge vclk) begin
        vid_rddata <= mem[vid_addr];
    end

endmodule

/* src/text_pixel.sv */
module text_pixel #(
    parameter int columns = 80
) (
    input  logic                           vclk,
    input  logic                           reset,
    input  video_pkg::video_timing_s       timing,
    input  video_pkg::video_ctrl_s         ctrl,
    output logic [video_pkg::tram_aw-1:0]  tram_vaddr,
    input  logic [15:0]                    tram_vdata,
    output logic [video_pkg::chram_aw-1:0] chram_vaddr,
    input  logic [7:0]                     chram_vdata,
    output logic [video_pkg::colidx_w-1:0] colidx,
    output video_pkg::video_timing_s       timing_out
);
    import video_pkg::*;

    logic [15:0]         text_addr;     // Full width, before the RAM
    video_timing_s       timing_s1;
    video_timing_s       timing_s2;
    logic [2:0]          glyph_row_s1;
    logic [2:0]          xbit_s1;
    logic [2:0]          xbit_s2;
    logic [7:0]          colour_s2;
    logic                glyph_bit;
    logic                use_fg;
    logic [colidx_w-1:0] idx_next;

    //////////////////////////////////////////////////
    // Stage 0: text word address

    assign text_addr  = 16'(timing.vpos[9:4]) * 16'(columns) + 16'(timing.hpos[10:3]);
    assign tram_vaddr = text_addr[tram_aw-1:0];

    //////////////////////////////////////////////////
    // Stage 1: text word in, glyph fetch

    always_ff @(posedge vclk) begin
        glyph_row_s1 <= timing.vpos[3:1];  // Font rows doubled
        xbit_s1      <= timing.hpos[2:0];
        xbit_s2      <= xbit_s1;
        colour_s2    <= tram_vdata[15:8];  // Rides along with the glyph read
    end

    assign chram_vaddr = {tram_vdata[7:0], glyph_row_s1};

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            timing_s1  <= timing_idle;
            timing_s2  <= timing_idle;
            timing_out <= timing_idle;
        end else begin
            timing_s1  <= timing;
            timing_s2  <= timing_s1;
            timing_out <= timing_s2;
        end
    end

    //////////////////////////////////////////////////
    // Stage 2: glyph bit and nibble select

    assign glyph_bit = chram_vdata[3'd7 - xbit_s2];
    assign use_fg    = glyph_bit ^ ctrl.invert;
    assign idx_next  = !ctrl.text_enable ? '0 :
                       use_fg ? colour_s2[7:4] : colour_s2[3:0];

    always_ff @(posedge vclk) begin
        colidx <= idx_next;
    end

    // The timing's active area must fit the text grid and the text RAM
    assert property (@(posedge vclk) disable iff (reset)
        timing.active |-> (timing.hpos[10:3] < 8'(columns)) && (text_addr < 16'(2**tram_aw)))
        else $error("Text address outside the screen grid");

endmodule

/* src/palette.sv */
module palette (
    input  logic                           vclk,
    input  video_pkg::pal_wr_s             pal_wr,
    input  logic [3:0]                     cpu_idx,
    input  logic                           cpu_high,
    output logic [7:0]                     cpu_rddata,
    input  logic [video_pkg::colidx_w-1:0] colidx,
    output logic [3:0]                     red,
    output logic [3:0]                     green,
    output logic [3:0]                     blue
);
    import video_pkg::*;

    logic [11:0] entry [2**colidx_w];   // {red, green, blue}

    always_ff @(posedge vclk) begin
        if (pal_wr.wren) begin
            if (pal_wr.high) begin
                entry[pal_wr.idx][11:8] <= pal_wr.data[3:0];
            end else begin
                entry[pal_wr.idx][7:0] <= pal_wr.data;
            end
        end
    end

    // Video lookup
    always_ff @(posedge vclk) begin
        {red, green, blue} <= entry[colidx];
    end

    // High byte has only the red nibble
    assign cpu_rddata = cpu_high ? {4'h0, entry[cpu_idx][11:8]} : entry[cpu_idx][7:0];

endmodule

/* src/video.sv */
module video #(
    parameter int h_active = 640,
    parameter int h_front  = 16,
    parameter int h_sync   = 96,
    parameter int h_back   = 48,
    parameter int v_active = 480,
    parameter int v_front  = 10,
    parameter int v_sync   = 2,
    parameter int v_back   = 33
) (
    input  logic                           vclk,
    input  logic                           reset,
    input  logic [3:0]                     io_addr,
    input  logic [7:0]                     io_wrdata,
    input  logic                           io_wren,
    output logic [7:0]                     io_rddata,
    output logic                           irq,
    input  logic [video_pkg::tram_aw:0]    tram_addr,
    input  logic [7:0]                     tram_wrdata,
    input  logic                           tram_wren,
    output logic [7:0]                     tram_rddata,
    input  logic [video_pkg::chram_aw-1:0] chram_addr,
    input  logic [7:0]                     chram_wrdata,
    input  logic                           chram_wren,
    output logic [7:0]                     chram_rddata,
    output logic [3:0]                     vga_r,
    output logic [3:0]                     vga_g,
    output logic [3:0]                     vga_b,
    output logic                           vga_de,
    output logic                           vga_hsync,
    output logic                           vga_vsync
);
    import video_pkg::*;

    localparam int columns = h_active / 8;

    video_timing_s       timing;
    video_timing_s       timing_px;     // From the text pipeline
    video_timing_s       timing_pal;    // Lined up with palette output
    video_ctrl_s         ctrl;
    pal_wr_s             pal_wr;
    logic [7:0]          pal_rddata;
    logic [tram_aw-1:0]  tram_vaddr;
    logic [15:0]         tram_vdata;
    logic [chram_aw-1:0] chram_vaddr;
    logic [7:0]          chram_vdata;
    logic [colidx_w-1:0] colidx;
    logic [3:0]          pal_r;
    logic [3:0]          pal_g;
    logic [3:0]          pal_b;

    video_timing #(
        .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
        .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
    ) i_timing (
        .vclk(vclk), .reset(reset), .timing(timing)
    );

    video_regs i_regs (
        .vclk(vclk), .reset(reset), .timing(timing),
        .io_addr(io_addr), .io_wrdata(io_wrdata), .io_wren(io_wren),
        .io_rddata(io_rddata), .irq(irq), .ctrl(ctrl),
        .pal_wr(pal_wr), .pal_rddata(pal_rddata)
    );

    text_ram i_text_ram (
        .vclk(vclk), .cpu_addr(tram_addr), .cpu_wrdata(tram_wrdata),
        .cpu_wren(tram_wren), .cpu_rddata(tram_rddata),
        .vid_addr(tram_vaddr), .vid_rddata(tram_vdata)
    );

    char_ram i_char_ram (
        .vclk(vclk), .cpu_addr(chram_addr), .cpu_wrdata(chram_wrdata),
        .cpu_wren(chram_wren), .cpu_rddata(chram_rddata),
        .vid_addr(chram_vaddr), .vid_rddata(chram_vdata)
    );

    text_pixel #(.columns(columns)) i_text_pixel (
        .vclk(vclk), .reset(reset), .timing(timing), .ctrl(ctrl),
        .tram_vaddr(tram_vaddr), .tram_vdata(tram_vdata),
        .chram_vaddr(chram_vaddr), .chram_vdata(chram_vdata),
        .colidx(colidx), .timing_out(timing_px)
    );

    // CPU side addressed through vpalsel
    palette i_palette (
        .vclk(vclk), .pal_wr(pal_wr), .cpu_idx(pal_wr.idx), .cpu_high(pal_wr.high),
        .cpu_rddata(pal_rddata), .colidx(colidx),
        .red(pal_r), .green(pal_g), .blue(pal_b)
    );

    //////////////////////////////////////////////////
    // Output registers

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            timing_pal <= timing_idle;
            vga_r      <= '0;
            vga_g      <= '0;
            vga_b      <= '0;
            vga_de     <= 1'b0;
            vga_hsync  <= 1'b1;
            vga_vsync  <= 1'b1;
        end else begin
            timing_pal <= timing_px;
            vga_r      <= timing_pal.active ? pal_r : 4'h0;   // Blank outside active area
            vga_g      <= timing_pal.active ? pal_g : 4'h0;
            vga_b      <= timing_pal.active ? pal_b : 4'h0;
            vga_de     <= timing_pal.active;
            vga_hsync  <= timing_pal.hsync;
            vga_vsync  <= timing_pal.vsync;
        end
    end

endmodule

/* test/video_tb.sv */
module video_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import video_pkg::*;

    localparam int wait_limit = 4000;   // Longer than one frame of 80 x 38 cycles

    typedef enum {p_hsync, p_vsync, p_de, p_irq} probe_e;

    logic        vclk = 1'b0;
    logic        reset;
    logic [3:0]  io_addr;
    logic [7:0]  io_wrdata;
    logic        io_wren;
    logic [7:0]  io_rddata;
    logic        irq;
    logic [12:0] tram_addr;
    logic [7:0]  tram_wrdata;
    logic        tram_wren;
    logic [7:0]  tram_rddata;
    logic [10:0] chram_addr;
    logic [7:0]  chram_wrdata;
    logic        chram_wren;
    logic [7:0]  chram_rddata;
    logic [3:0]  vga_r;
    logic [3:0]  vga_g;
    logic [3:0]  vga_b;
    logic        vga_de;
    logic        vga_hsync;
    logic        vga_vsync;

    logic [31:0] lfsr = 32'h80e1_42a0;
    logic [7:0]  text_chr [16];     // 8 columns x 2 rows
    logic [7:0]  text_col [16];
    logic [7:0]  glyph_ref [2048];
    logic [11:0] pal_ref [16];
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          timeouts = 0;
    int          errors_before = 0;

    video #(
        .h_active(64), .h_front(4), .h_sync(8), .h_back(4),
        .v_active(32), .v_front(2), .v_sync(2), .v_back(2)
    ) i_video (.*);

    always #4 vclk = ~vclk;

    // Blanked colour outside the active area
    assert property (@(posedge vclk) disable iff (reset)
        !vga_de |-> ({vga_r, vga_g, vga_b} == 12'h000))
        else begin
            errors++;
            $display("Error vga_rgb: %h while vga_de is low, expected 000",
                     $sampled({vga_r, vga_g, vga_b}));
        end

    //////////////////////////////////////////////////
    // Helpers

    // Galois LFSR, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic probe(input probe_e sig);
        case (sig)
            p_hsync: return vga_hsync;
            p_vsync: return vga_vsync;
            p_de:    return vga_de;
            default: return irq;
        endcase
    endfunction

    // Text cell, glyph row doubled, MSB leftmost
    function automatic logic [11:0] expected_rgb(input int x, input int y, input logic [1:0] vctrl);
        int         word;
        logic [7:0] glyph;
        logic [7:0] colour;
        logic       fg;
        word   = (y / 16) * 8 + x / 8;
        colour = text_col[word];
        glyph  = glyph_ref[text_chr[word] * 8 + (y / 2) % 8];
        fg     = glyph[7 - x % 8] ^ vctrl[1];
        if (!vctrl[0]) begin
            return pal_ref[0];
        end
        return fg ? pal_ref[colour[7:4]] : pal_ref[colour[3:0]];
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
            else begin
                errors++;
                $display("Error %s: got %h, expected %h", name, got, exp);
            end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%s: finished with %0d errors", name, errors - errors_before);
        errors_before = errors;
    endtask

    task automatic count_while(input probe_e sig, input logic level, output int n);
        n = 0;
        while (probe(sig) === level && n <= wait_limit) begin
            @(negedge vclk);
            n++;
        end
        if (n > wait_limit) begin
            timeouts++;
            $display("Timeout: %s stuck at %b", sig.name(), level);
        end
    endtask

    task automatic wait_until(input probe_e sig, input logic level);
        int n;
        count_while(sig, !level, n);
    endtask

    task automatic wait_vsync_pulse();
        wait_until(p_vsync, 1'b0);
        wait_until(p_vsync, 1'b1);
    endtask

    //////////////////////////////////////////////////
    // CPU ports

    task automatic reg_write(input logic [3:0] a, input logic [7:0] d);
        @(negedge vclk);
        io_addr   = a;
        io_wrdata = d;
        io_wren   = 1'b1;
        @(negedge vclk);
        io_wren = 1'b0;
    endtask

    task automatic reg_read(input logic [3:0] a, output logic [7:0] d);
        @(negedge vclk);
        io_addr = a;
        io_wren = 1'b0;
        @(negedge vclk);
        d = io_rddata;
    endtask

    // glyph selects the character RAM, else the text RAM
    task automatic mem_write(input bit glyph, input logic [12:0] a, input logic [7:0] d);
        @(negedge vclk);
        tram_addr    = a;
        tram_wrdata  = d;
        tram_wren    = !glyph;
        chram_addr   = a[10:0];
        chram_wrdata = d;
        chram_wren   = glyph;
        @(negedge vclk);
        tram_wren  = 1'b0;
        chram_wren = 1'b0;
    endtask

    task automatic mem_read(input bit glyph, input logic [12:0] a, output logic [7:0] d);
        @(negedge vclk);
        tram_addr  = a;
        chram_addr = a[10:0];
        @(negedge vclk);
        d = glyph ? chram_rddata : tram_rddata;
    endtask

    task automatic set_palette(input int idx, input logic [11:0] rgb);
        pal_ref[idx] = rgb;
        reg_write(reg_vpalsel, {3'b000, 4'(idx), 1'b1});
        reg_write(reg_vpaldata, {4'h0, rgb[11:8]});
        reg_write(reg_vpalsel, {3'b000, 4'(idx), 1'b0});
        reg_write(reg_vpaldata, rgb[7:0]);
    endtask

    // One full frame of pixels against the reference arrays
    task automatic check_frame(input logic [1:0] vctrl);
        int x;
        int y;
        int n;
        int extra;
        wait_vsync_pulse();
        for (y = 0; y < 32; y++) begin
            wait_until(p_de, 1'b1);
            for (x = 0; x < 64; x++) begin
                expect_eq("vga_de", vga_de, 1'b1);
                expect_eq("vga_rgb", {vga_r, vga_g, vga_b}, expected_rgb(x, y, vctrl));
                @(negedge vclk);
            end
            expect_eq("vga_de", vga_de, 1'b0);      // 64 pixels per line
        end
        extra = 0;
        n = 0;
        while (vga_vsync !== 1'b0 && n <= wait_limit) begin
            if (vga_de === 1'b1) extra++;
            @(negedge vclk);
            n++;
        end
        if (n > wait_limit) begin
            timeouts++;
            $display("Timeout: no vsync after the last active line");
        end
        expect_eq("vga_de after line 31", extra, 0);
    endtask

    //////////////////////////////////////////////////
    // Stimulus

    initial begin
        int          i;
        int          w;
        int          r;
        int          n;
        int          low;
        int          high;
        int          lines;
        logic        de_q;
        logic [7:0]  rd;
        logic [10:0] ga;
        reset        = 1'b1;
        io_addr      = '0;
        io_wrdata    = '0;
        io_wren      = 1'b0;
        tram_addr    = '0;
        tram_wrdata  = '0;
        tram_wren    = 1'b0;
        chram_addr   = '0;
        chram_wrdata = '0;
        chram_wren   = 1'b0;
        repeat (2) @(negedge vclk);
        reset = 1'b0;

        // Reset state and register access
        @(negedge vclk);
        expect_eq("vga_de", vga_de, 1'b0);
        expect_eq("vga_hsync", vga_hsync, 1'b1);
        expect_eq("vga_vsync", vga_vsync, 1'b1);
        expect_eq("irq", irq, 1'b0);
        for (i = 0; i < 16; i++) begin
            if (i != reg_vpaldata) begin   // Palette has no reset
                reg_read(4'(i), rd);
                // Line 0 already matched the reset virqline of 0
                expect_eq($sformatf("io_rddata[%0d]", i), rd,
                          (i == reg_irqstat) ? 8'h02 : 8'h00);
            end
        end
        reg_write(reg_vctrl, 8'h03);
        reg_read(reg_vctrl, rd);
        expect_eq("vctrl", rd, 8'h03);
        reg_write(reg_vctrl, 8'h00);
        reg_write(reg_vpalsel, 8'h1b);
        reg_read(reg_vpalsel, rd);
        expect_eq("vpalsel", rd, 8'h1b);
        reg_write(reg_virqline, 8'ha5);
        reg_read(reg_virqline, rd);
        expect_eq("virqline", rd, 8'ha5);
        for (i = 0; i < 16; i++) begin
            set_palette(i, 12'(take_bits(12)));
        end
        for (i = 0; i < 16; i++) begin
            reg_write(reg_vpalsel, {3'b000, 4'(i), 1'b1});
            reg_read(reg_vpaldata, rd);
            expect_eq("vpaldata high", rd, {4'h0, pal_ref[i][11:8]});
            reg_write(reg_vpalsel, {3'b000, 4'(i), 1'b0});
            reg_read(reg_vpaldata, rd);
            expect_eq("vpaldata low", rd, pal_ref[i][7:0]);
        end
        for (w = 0; w < 16; w++) begin
            text_chr[w] = 8'(take_bits(8));
            text_col[w] = 8'(take_bits(8));
            mem_write(1'b0, 13'(w * 2), text_chr[w]);
            mem_write(1'b0, 13'(w * 2 + 1), text_col[w]);
        end
        for (w = 0; w < 16; w++) begin
            for (r = 0; r < 8; r++) begin
                ga = {text_chr[w], 3'(r)};
                glyph_ref[ga] = 8'(take_bits(8));
                mem_write(1'b1, 13'(ga), glyph_ref[ga]);
            end
        end
        for (w = 0; w < 16; w++) begin
            mem_read(1'b0, 13'(w * 2), rd);
            expect_eq("tram_rddata", rd, text_chr[w]);
            mem_read(1'b0, 13'(w * 2 + 1), rd);
            expect_eq("tram_rddata", rd, text_col[w]);
            for (r = 0; r < 8; r++) begin
                ga = {text_chr[w], 3'(r)};
                mem_read(1'b1, 13'(ga), rd);
                expect_eq("chram_rddata", rd, glyph_ref[ga]);
            end
        end
        end_test("reset and registers");

        wait_until(p_hsync, 1'b1);
        wait_until(p_hsync, 1'b0);
        count_while(p_hsync, 1'b0, low);
        count_while(p_hsync, 1'b1, high);
        expect_eq("hsync low cycles", low, 8);
        expect_eq("hsync period", low + high, 80);
        check_frame(2'b00);    // Text off, entry 0 everywhere
        end_test("sync timing");

        reg_write(reg_vctrl, 8'h01);
        check_frame(2'b01);
        end_test("text rendering");

        reg_write(reg_vctrl, 8'h03);
        check_frame(2'b11);
        reg_write(reg_vctrl, 8'h02);
        check_frame(2'b10);
        end_test("control bits");

        // Line 5 of the doubled grid is display line 10
        reg_write(reg_virqline, 8'd5);
        reg_write(reg_irqmask, 8'h02);
        wait_vsync_pulse();
        reg_write(reg_irqstat, 8'h03);
        expect_eq("irq", irq, 1'b0);
        wait_until(p_irq, 1'b1);
        reg_read(reg_irqstat, rd);
        expect_eq("irqstat", rd, 8'h02);
        reg_read(reg_vline, rd);
        expect_eq("vline", rd, 8'd5);
        reg_write(reg_irqstat, 8'h02);
        expect_eq("irq", irq, 1'b0);
        reg_write(reg_irqmask, 8'h00);
        wait_vsync_pulse();
        reg_write(reg_irqstat, 8'h03);
        n = 0;
        rd = '0;
        while (!rd[1] && n <= wait_limit) begin
            reg_read(reg_irqstat, rd);
            expect_eq("irq", irq, 1'b0);   // Masked
            n++;
        end
        if (n > wait_limit) begin
            timeouts++;
            $display("Timeout: line status never set with the mask clear");
        end
        expect_eq("irqstat", rd, 8'h02);
        end_test("line interrupt");

        reg_write(reg_irqmask, 8'h01);
        wait_vsync_pulse();
        reg_write(reg_irqstat, 8'h03);
        expect_eq("irq", irq, 1'b0);
        for (i = 0; i < 2; i++) begin
            lines = 0;
            n = 0;
            de_q = vga_de;
            while (irq !== 1'b1 && n <= wait_limit) begin
                @(negedge vclk);
                if (vga_de && !de_q) lines++;
                de_q = vga_de;
                n++;
            end
            if (n > wait_limit) begin
                timeouts++;
                $display("Timeout: no vblank interrupt");
            end
            expect_eq("vga_de lines before vblank irq", lines, 32);
            reg_write(reg_irqstat, 8'h01);
            expect_eq("irq", irq, 1'b0);
        end
        end_test("vblank interrupt");

        $display("%0d tests, %0d checks, %0d errors, %0d timeouts",
                 tests, checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
src/video_pkg.sv
src/video_timing.sv
src/video_regs.sv
src/text_ram.sv
src/char_ram.sv
src/text_pixel.sv
src/palette.sv
src/video.sv
test/video_tb.sv
